// ==== design/fcvt_macros.svh ====
`ifndef FCVT_MACROS_SVH
`define FCVT_MACROS_SVH

// single precision float format
`define FCVT_EXP_BITS 8
`define FCVT_MAN_BITS 23
`define FCVT_EXP_BIAS 127

// integer side
`define FCVT_INT_W 32

// internal datapath widths
`define FCVT_MANT_W 32   // max of int width and mantissa plus hidden bit
`define FCVT_EXP_W 10    // signed exponent, holds the smallest subnormal
`define FCVT_LZC_W 5
`define FCVT_SHAMT_W 6
`define FCVT_TAG_W 4

`endif

// ==== design/fcvt_pkg.sv ====
`include "fcvt_macros.svh"

package fcvt_pkg;

    typedef enum logic [1:0] {
        OP_F2I_S,
        OP_F2I_U,
        OP_I2F_S,
        OP_I2F_U
    } fcvt_op_e;

    typedef struct packed {
        logic is_zero;
        logic is_subnormal;
        logic is_normal;
        logic is_inf;
        logic is_nan;
        logic is_signaling;
    } fp_class_t;

    typedef struct packed {
        logic nv;
        logic dz;   // never set, no division here
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef struct packed {
        fcvt_op_e               op;
        logic [`FCVT_INT_W-1:0] operand;
        logic [`FCVT_TAG_W-1:0] tag;
    } cvt_req_t;

    typedef struct packed {
        logic [`FCVT_INT_W-1:0] result;
        fflags_t                flags;
        logic [`FCVT_TAG_W-1:0] tag;
    } cvt_rsp_t;

    typedef struct packed {
        logic                    valid;
        fcvt_op_e                op;
        logic [`FCVT_TAG_W-1:0]  tag;
        fp_class_t               cls;
        logic                    sign;
        logic [`FCVT_EXP_W-1:0]  exp;    // raw exponent field, zero extended
        logic [`FCVT_MANT_W-1:0] mant;   // hidden bit + fraction, or |int|
    } s0_t;

    typedef struct packed {
        logic                    valid;
        fcvt_op_e                op;
        logic [`FCVT_TAG_W-1:0]  tag;
        fp_class_t               cls;
        logic                    sign;
        logic                    mant_zero;
        logic [`FCVT_MANT_W-1:0] mant;   // msb set unless zero
        logic [`FCVT_EXP_W-1:0]  exp;    // unbiased
    } s1_t;

    typedef struct packed {
        logic                    valid;
        fcvt_op_e                op;
        logic [`FCVT_TAG_W-1:0]  tag;
        fp_class_t               cls;
        logic                    sign;
        logic                    mant_zero;
        logic [2*`FCVT_MANT_W:0] mant;
        logic [`FCVT_EXP_W-1:0]  exp;
        logic                    of_pre;
    } s2_t;

    typedef struct packed {
        logic                   valid;
        fcvt_op_e               op;
        logic [`FCVT_TAG_W-1:0] tag;
        fp_class_t              cls;
        logic                   sign;
        logic                   mant_zero;
        logic                   of_pre;
        logic [`FCVT_INT_W-1:0] abs;
        logic                   rnd_sign;
        logic [1:0]             rs;     // round, sticky of the destination format
    } s3_t;

    function automatic logic op_is_itof(fcvt_op_e op);
        return (op == OP_I2F_S) || (op == OP_I2F_U);
    endfunction

    function automatic logic op_is_signed(fcvt_op_e op);
        return (op == OP_F2I_S) || (op == OP_I2F_S);
    endfunction

endpackage

// ==== design/fcvt_unpack.sv ====
`include "fcvt_macros.svh"

module fcvt_unpack (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               stall_i,
    input  logic               valid_i,
    input  fcvt_pkg::cvt_req_t req_i,
    output fcvt_pkg::s0_t      s0_o
);
    import fcvt_pkg::*;

    logic [`FCVT_EXP_BITS-1:0] exp_field;
    logic [`FCVT_MAN_BITS-1:0] man_field;
    logic                      exp_ones;
    logic                      itof;
    logic                      int_sign;
    logic [`FCVT_MANT_W-1:0]   int_mant;
    logic [`FCVT_MANT_W-1:0]   fmt_mant;
    fp_class_t                 cls;
    s0_t                       s0_d;
    s0_t                       s0_q;

    assign exp_field = req_i.operand[`FCVT_MAN_BITS +: `FCVT_EXP_BITS];
    assign man_field = req_i.operand[`FCVT_MAN_BITS-1:0];
    assign exp_ones  = (exp_field == '1);

    // float operand class
    assign cls.is_zero      = (exp_field == '0) && (man_field == '0);
    assign cls.is_subnormal = (exp_field == '0) && (man_field != '0);
    assign cls.is_normal    = (exp_field != '0) && !exp_ones;
    assign cls.is_inf       = exp_ones && (man_field == '0);
    assign cls.is_nan       = exp_ones && (man_field != '0);
    assign cls.is_signaling = cls.is_nan && !man_field[`FCVT_MAN_BITS-1];   // quiet bit clear

    assign itof     = op_is_itof(req_i.op);
    assign int_sign = req_i.operand[`FCVT_INT_W-1] & op_is_signed(req_i.op);
    assign int_mant = int_sign ? -req_i.operand : req_i.operand;   // magnitude
    assign fmt_mant = `FCVT_MANT_W'({cls.is_normal, man_field});   // hidden bit + fraction

    always_comb begin
        s0_d.valid = valid_i;
        s0_d.op    = req_i.op;
        s0_d.tag   = req_i.tag;
        s0_d.cls   = cls;
        s0_d.sign  = itof ? int_sign : req_i.operand[`FCVT_INT_W-1];
        s0_d.exp   = `FCVT_EXP_W'(exp_field);
        s0_d.mant  = itof ? int_mant : fmt_mant;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s0_q.valid <= 1'b0;
        end else if (!stall_i) begin
            s0_q <= s0_d;
        end
    end

    assign s0_o = s0_q;

endmodule

// ==== design/fcvt_normalize.sv ====
`include "fcvt_macros.svh"

module fcvt_normalize (
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic          stall_i,
    input  fcvt_pkg::s0_t s0_i,
    output fcvt_pkg::s1_t s1_o
);
    import fcvt_pkg::*;

    logic [`FCVT_LZC_W-1:0] lzc;
    logic                   mant_zero;
    logic [`FCVT_EXP_W-1:0] int_exp;
    logic [`FCVT_EXP_W-1:0] fp_exp;
    s1_t                    s1_d;
    s1_t                    s1_q;

    // leading zero count, highest set bit wins
    always_comb begin
        lzc = '0;
        for (int i = 0; i < `FCVT_MANT_W; i++) begin
            if (s0_i.mant[i]) begin
                lzc = `FCVT_LZC_W'(`FCVT_MANT_W - 1 - i);
            end
        end
    end

    assign mant_zero = (s0_i.mant == '0);   // integer zero

    assign int_exp = `FCVT_EXP_W'(`FCVT_MANT_W - 1) - `FCVT_EXP_W'(lzc);

    // subnormals use exponent 1, then undo the hidden-bit offset and the bias
    assign fp_exp = s0_i.exp + `FCVT_EXP_W'(s0_i.cls.is_subnormal)
                  + `FCVT_EXP_W'(`FCVT_MANT_W - 1 - `FCVT_MAN_BITS - `FCVT_EXP_BIAS)
                  - `FCVT_EXP_W'(lzc);

    always_comb begin
        s1_d.valid     = s0_i.valid;
        s1_d.op        = s0_i.op;
        s1_d.tag       = s0_i.tag;
        s1_d.cls       = s0_i.cls;
        s1_d.sign      = s0_i.sign;
        s1_d.mant_zero = mant_zero;
        s1_d.mant      = s0_i.mant << lzc;
        s1_d.exp       = op_is_itof(s0_i.op) ? int_exp : fp_exp;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s1_q.valid <= 1'b0;
        end else if (!stall_i) begin
            s1_q <= s1_d;
        end
    end

    assign s1_o = s1_q;

endmodule

// ==== design/fcvt_align.sv ====
`include "fcvt_macros.svh"

module fcvt_align (
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic          stall_i,
    input  fcvt_pkg::s1_t s1_i,
    output fcvt_pkg::s2_t s2_o
);
    import fcvt_pkg::*;

    logic [`FCVT_EXP_W-1:0]   dest_exp;    // rebiased for float results
    logic [2*`FCVT_MANT_W:0]  preshift;
    logic [`FCVT_SHAMT_W-1:0] shamt;
    logic [`FCVT_EXP_W-1:0]   final_exp;
    logic                     of_pre;
    logic                     uns;
    s2_t                      s2_d;
    s2_t                      s2_q;

    assign dest_exp = s1_i.exp + `FCVT_EXP_W'(`FCVT_EXP_BIAS);
    assign uns      = !op_is_signed(s1_i.op);

    always_comb begin
        final_exp = dest_exp;
        preshift  = {s1_i.mant, {(`FCVT_MANT_W + 1){1'b0}}};   // mantissa at the top
        shamt     = '0;
        of_pre    = 1'b0;
        if (op_is_itof(s1_i.op)) begin
            if ($signed(dest_exp) >= (2**`FCVT_EXP_BITS - 1)) begin
                final_exp = `FCVT_EXP_W'(2**`FCVT_EXP_BITS - 2);   // largest normal
                preshift  = '1;                                     // R and S set too
                of_pre    = 1'b1;
            end else if ($signed(dest_exp) < -`FCVT_MAN_BITS) begin
                // cap the shift so the sticky bit survives
                final_exp = '0;
                shamt     = `FCVT_SHAMT_W'(`FCVT_MAN_BITS + 2);
            end else if ($signed(dest_exp) < 1) begin
                final_exp = '0;   // subnormal result
                shamt     = `FCVT_SHAMT_W'(1 - $signed(dest_exp));
            end
        end else begin
            if ($signed(s1_i.exp) >= (`FCVT_INT_W - 1) + int'(uns)) begin
                of_pre = 1'b1;   // unsigned range is one bit wider
            end else if ($signed(s1_i.exp) < -1) begin
                shamt = `FCVT_SHAMT_W'(`FCVT_INT_W + 1);   // all into sticky
            end else begin
                shamt = `FCVT_SHAMT_W'((`FCVT_INT_W - 1) - $signed(s1_i.exp));
            end
        end
    end

    always_comb begin
        s2_d.valid     = s1_i.valid;
        s2_d.op        = s1_i.op;
        s2_d.tag       = s1_i.tag;
        s2_d.cls       = s1_i.cls;
        s2_d.sign      = s1_i.sign;
        s2_d.mant_zero = s1_i.mant_zero;
        s2_d.mant      = preshift >> shamt;
        s2_d.exp       = final_exp;
        s2_d.of_pre    = of_pre;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s2_q.valid <= 1'b0;
        end else if (!stall_i) begin
            s2_q <= s2_d;
        end
    end

    assign s2_o = s2_q;

endmodule

// ==== design/fcvt_round.sv ====
`include "fcvt_macros.svh"

module fcvt_round (
    input  logic          clk_i,
    input  logic          reset_i,
    input  logic          stall_i,
    input  fcvt_pkg::s2_t s2_i,
    output fcvt_pkg::s3_t s3_o
);
    import fcvt_pkg::*;

    logic [`FCVT_MAN_BITS-1:0] final_mant;
    logic [`FCVT_INT_W-1:0]    final_int;
    logic [1:0]                fp_rs;
    logic [1:0]                int_rs;
    logic [1:0]                rs;
    logic [`FCVT_INT_W-1:0]    pre_round;
    logic                      round_up;
    logic                      itof;
    s3_t                       s3_d;
    s3_t                       s3_o_q;

    assign itof = op_is_itof(s2_i.op);

    // float candidate, top bit is the hidden one and is dropped
    assign final_mant = s2_i.mant[2*`FCVT_MANT_W-1 -: `FCVT_MAN_BITS];
    assign fp_rs[1]   = s2_i.mant[2*`FCVT_MANT_W-1-`FCVT_MAN_BITS];
    assign fp_rs[0]   = |s2_i.mant[2*`FCVT_MANT_W-2-`FCVT_MAN_BITS:0];

    // integer candidate
    assign final_int = s2_i.mant[2*`FCVT_MANT_W -: `FCVT_INT_W];
    assign int_rs[1] = s2_i.mant[2*`FCVT_MANT_W-`FCVT_INT_W];
    assign int_rs[0] = |s2_i.mant[2*`FCVT_MANT_W-`FCVT_INT_W-1:0];

    assign rs        = itof ? fp_rs : int_rs;
    assign pre_round = itof ? {1'b0, s2_i.exp[`FCVT_EXP_BITS-1:0], final_mant} : final_int;

    // nearest even, a mantissa carry rolls into the exponent
    assign round_up = rs[1] & (rs[0] | pre_round[0]);

    always_comb begin
        s3_d.valid     = s2_i.valid;
        s3_d.op        = s2_i.op;
        s3_d.tag       = s2_i.tag;
        s3_d.cls       = s2_i.cls;
        s3_d.sign      = s2_i.sign;
        s3_d.mant_zero = s2_i.mant_zero;
        s3_d.of_pre    = s2_i.of_pre;
        s3_d.abs       = pre_round + `FCVT_INT_W'(round_up);
        s3_d.rnd_sign  = s2_i.sign;   // RNE keeps the sign
        s3_d.rs        = rs;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s3_o_q.valid <= 1'b0;
        end else if (!stall_i) begin
            s3_o_q <= s3_d;
        end
    end

    assign s3_o = s3_o_q;

endmodule

// ==== design/fcvt_finish.sv ====
`include "fcvt_macros.svh"

module fcvt_finish (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               stall_i,
    input  fcvt_pkg::s3_t      s3_i,
    output logic               valid_o,
    output fcvt_pkg::cvt_rsp_t rsp_o
);
    import fcvt_pkg::*;

    logic                   itof;
    logic                   uns;
    logic                   of_post;
    logic                   uf_post;
    logic [`FCVT_INT_W-1:0] fmt_result;
    logic [`FCVT_INT_W-1:0] int_result;
    logic [`FCVT_INT_W-1:0] int_special;
    logic                   int_is_special;
    fflags_t                fp_flags;
    fflags_t                int_flags;
    cvt_rsp_t               rsp_d;
    cvt_rsp_t               rsp_q;
    logic                   valid_q;

    assign itof = op_is_itof(s3_i.op);
    assign uns  = !op_is_signed(s3_i.op);

    // float result, exponent field decides post-round class
    assign fmt_result = (itof & s3_i.mant_zero) ? '0 :
                        {s3_i.rnd_sign, s3_i.abs[`FCVT_INT_W-2:0]};
    assign of_post    = (s3_i.abs[`FCVT_MAN_BITS +: `FCVT_EXP_BITS] == '1);
    assign uf_post    = (s3_i.abs[`FCVT_MAN_BITS +: `FCVT_EXP_BITS] == '0);

    assign int_result = s3_i.rnd_sign ? -s3_i.abs : s3_i.abs;   // back to two's complement

    // saturation value
    always_comb begin
        if (s3_i.sign && !s3_i.cls.is_nan) begin
            int_special = {~uns, {(`FCVT_INT_W - 1){1'b0}}};
        end else begin
            int_special = {uns, {(`FCVT_INT_W - 1){1'b1}}};
        end
    end

    assign int_is_special = s3_i.cls.is_nan | s3_i.cls.is_inf | s3_i.of_pre
                          | (s3_i.sign & uns & (int_result != '0));   // negative into unsigned

    always_comb begin
        fp_flags    = '0;
        fp_flags.nv = s3_i.of_pre | of_post;
        fp_flags.nx = |s3_i.rs;
        fp_flags.uf = fp_flags.nx & uf_post;
        int_flags    = '0;
        int_flags.nv = int_is_special;
        int_flags.nx = !int_is_special & (|s3_i.rs);
    end

    always_comb begin
        rsp_d.tag = s3_i.tag;
        if (itof) begin
            rsp_d.result = fmt_result;
            rsp_d.flags  = fp_flags;
        end else begin
            rsp_d.result = int_is_special ? int_special : int_result;
            rsp_d.flags  = int_flags;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= s3_i.valid;
            rsp_q   <= rsp_d;
        end
    end

    assign valid_o = valid_q;
    assign rsp_o   = rsp_q;

endmodule

// ==== design/fcvt_top.sv ====
module fcvt_top (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               valid_i,
    output logic               ready_o,
    input  fcvt_pkg::cvt_req_t req_i,
    output logic               valid_o,
    input  logic               ready_i,
    output fcvt_pkg::cvt_rsp_t rsp_o
);
    fcvt_pkg::s0_t s0;
    fcvt_pkg::s1_t s1;
    fcvt_pkg::s2_t s2;
    fcvt_pkg::s3_t s3;
    logic          stall;

    // output held, every stage freezes
    assign stall   = valid_o & ~ready_i;
    assign ready_o = ~stall;

    fcvt_unpack u_unpack (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .stall_i (stall),
        .valid_i (valid_i),
        .req_i   (req_i),
        .s0_o    (s0)
    );

    fcvt_normalize u_normalize (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .stall_i (stall),
        .s0_i    (s0),
        .s1_o    (s1)
    );

    fcvt_align u_align (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .stall_i (stall),
        .s1_i    (s1),
        .s2_o    (s2)
    );

    fcvt_round u_round (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .stall_i (stall),
        .s2_i    (s2),
        .s3_o    (s3)
    );

    fcvt_finish u_finish (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .stall_i (stall),
        .s3_i    (s3),
        .valid_o (valid_o),
        .rsp_o   (rsp_o)
    );

endmodule

// ==== tests/fcvt_tb.sv ====
`include "fcvt_macros.svh"

module fcvt_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import fcvt_pkg::*;

    localparam logic [4:0] NV = 5'b10000;
    localparam logic [4:0] NX = 5'b00001;
    localparam int LATENCY = 5;   // acceptance edge counts as the first
    localparam int MAX_CYCLES = 200;

    logic     clk_i = 1'b0;
    logic     reset_i;
    logic     valid_i;
    logic     ready_o;
    cvt_req_t req_i;
    logic     valid_o;
    logic     ready_i;
    cvt_rsp_t rsp_o;

    cvt_req_t               pend[$];   // requests not yet accepted
    cvt_rsp_t               expq[$];   // expected responses in order
    logic [`FCVT_TAG_W-1:0] next_tag = '0;
    int                     err_cnt = 0;
    int                     pass_cnt = 0;
    int                     fail_cnt = 0;
    bit                     timed_out = 1'b0;

    always #10 clk_i = ~clk_i;

    fcvt_top dut0 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (valid_i),
        .ready_o (ready_o),
        .req_i   (req_i),
        .valid_o (valid_o),
        .ready_i (ready_i),
        .rsp_o   (rsp_o)
    );

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            err_cnt++;
        end
    endtask

    // integer to float reference with ties to even
    function automatic cvt_rsp_t ref_int_to_float(input logic [31:0] v, input bit sgn);
        logic [31:0] mag;
        logic [31:0] man;
        logic [30:0] body;
        bit          neg;
        bit          rb;
        bit          st;
        int          p;
        int          sh;
        cvt_rsp_t    r;
        r   = '0;
        neg = sgn && v[31];
        mag = neg ? -v : v;
        if (mag == 0) begin
            return r;
        end
        p = 31;
        while (!mag[p]) p--;
        rb = 1'b0;
        st = 1'b0;
        if (p <= 23) begin
            man = mag << (23 - p);   // fits exactly
        end else begin
            sh  = p - 23;
            man = mag >> sh;
            rb  = mag[sh-1];
            st  = (mag & ((32'd1 << (sh - 1)) - 1)) != 0;
        end
        body = {8'(127 + p), man[22:0]};
        if (rb && (st || man[0])) begin
            body = body + 1;   // carry may bump the exponent
        end
        r.result   = {neg, body};
        r.flags.nx = rb | st;
        return r;
    endfunction

    // float to int with saturation on invalid input
    function automatic cvt_rsp_t ref_float_to_int(input logic [31:0] f, input bit sgn);
        logic [7:0]  e;
        logic [63:0] mw;
        logic [63:0] mag;
        logic [63:0] lim;
        bit          neg;
        bit          nan;
        bit          big;
        bit          rb;
        bit          st;
        int          sh;
        cvt_rsp_t    r;
        r   = '0;
        e   = f[30:23];
        neg = f[31];
        nan = (e == 8'hff) && (f[22:0] != 0);
        mw  = (e == 0) ? {40'd0, 1'b0, f[22:0]} : {40'd0, 1'b1, f[22:0]};
        sh  = 150 - ((e == 0) ? 1 : int'(e));   // right shift down to the integer point
        big = 1'b0;
        rb  = 1'b0;
        st  = 1'b0;
        mag = '0;
        if (e == 8'hff) begin
            big = 1'b1;
        end else if (sh <= 0) begin
            if (-sh > 16) big = 1'b1;
            else mag = mw << (-sh);
        end else if (sh > 40) begin
            st = (mw != 0);
        end else begin
            mag = mw >> sh;
            rb  = mw[sh-1];
            st  = (mw & ((64'd1 << (sh - 1)) - 1)) != 0;
        end
        if (rb && (st || mag[0])) begin
            mag = mag + 1;
        end
        if (sgn) lim = neg ? 64'h8000_0000 : 64'h7fff_ffff;
        else lim = neg ? 64'h0 : 64'hffff_ffff;
        if (big || mag > lim) begin
            r.flags.nv = 1'b1;
            if (nan || !neg) r.result = sgn ? 32'h7fff_ffff : 32'hffff_ffff;
            else r.result = sgn ? 32'h8000_0000 : 32'h0;
        end else begin
            r.result   = neg ? -mag[31:0] : mag[31:0];
            r.flags.nx = rb | st;
        end
        return r;
    endfunction

    task automatic add_known(input fcvt_op_e op, input logic [31:0] operand,
                             input logic [31:0] result, input logic [4:0] flags);
        cvt_req_t q;
        cvt_rsp_t e;
        q.op      = op;
        q.operand = operand;
        q.tag     = next_tag;
        e.result  = result;
        e.flags   = flags;
        e.tag     = next_tag;
        pend.push_back(q);
        expq.push_back(e);
        next_tag++;
    endtask

    task automatic add_op(input fcvt_op_e op, input logic [31:0] operand);
        cvt_rsp_t e;
        case (op)
            OP_I2F_S: e = ref_int_to_float(operand, 1'b1);
            OP_I2F_U: e = ref_int_to_float(operand, 1'b0);
            OP_F2I_S: e = ref_float_to_int(operand, 1'b1);
            default:  e = ref_float_to_int(operand, 1'b0);
        endcase
        add_known(op, operand, e.result, e.flags);
    endtask

    task automatic compare_rsp(input cvt_rsp_t e);
        check_val("rsp_o.result", e.result, rsp_o.result);
        check_val("rsp_o.flags", 32'(e.flags), 32'(rsp_o.flags));
        check_val("rsp_o.tag", 32'(e.tag), 32'(rsp_o.tag));
    endtask

    // one cycle per pass from 2 ns after an edge
    task automatic run_ops(input bit random_ready);
        int       cycles;
        bit       held;
        cvt_rsp_t held_rsp;
        cycles = 0;
        held   = 1'b0;
        while ((pend.size() > 0 || expq.size() > 0) && cycles < MAX_CYCLES) begin
            ready_i = random_ready ? 1'($urandom % 2) : 1'b1;
            valid_i = (pend.size() > 0);
            if (pend.size() > 0) req_i = pend[0];
            #1;
            check_val("ready_o", 32'(!(valid_o && !ready_i)), 32'(ready_o));
            if (held) begin   // stalled output must not move
                check_val("valid_o", 32'd1, 32'(valid_o));
                check_val("rsp_o", held_rsp.result, rsp_o.result);
                check_val("rsp_o.flags", 32'(held_rsp.flags), 32'(rsp_o.flags));
                check_val("rsp_o.tag", 32'(held_rsp.tag), 32'(rsp_o.tag));
            end
            held     = valid_o && !ready_i;
            held_rsp = rsp_o;
            if (valid_o && ready_i) begin
                if (expq.size() == 0) begin
                    $display("result with tag %0d arrived but none was expected", rsp_o.tag);
                    err_cnt++;
                end else begin
                    compare_rsp(expq.pop_front());
                end
            end
            if (valid_i && ready_o) void'(pend.pop_front());
            @(posedge clk_i);
            #2;
            cycles++;
        end
        valid_i = 1'b0;
        ready_i = 1'b1;
        if (pend.size() > 0 || expq.size() > 0) begin
            $display("timeout: %0d requests and %0d results still outstanding",
                     pend.size(), expq.size());
            timed_out = 1'b1;
        end else begin
            check_val("valid_o", 32'd0, 32'(valid_o));   // nothing left in flight
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before && !timed_out) begin
            pass_cnt++;
            $display("%s: ok", name);
        end else begin
            fail_cnt++;
            $display("%s: failed", name);
        end
    endtask

    task automatic test_latency();
        int       errs;
        int       edges;
        cvt_rsp_t e;
        errs = err_cnt;
        check_val("valid_o", 32'd0, 32'(valid_o));
        check_val("ready_o", 32'd1, 32'(ready_o));
        e         = ref_int_to_float(32'd1000, 1'b1);
        e.tag     = next_tag;
        req_i.op  = OP_I2F_S;
        req_i.operand = 32'd1000;
        req_i.tag = next_tag;
        next_tag++;
        valid_i   = 1'b1;
        ready_i   = 1'b1;
        @(posedge clk_i);   // accepted here
        #2;
        valid_i = 1'b0;
        edges   = 1;
        while (!valid_o && edges < 20) begin
            @(posedge clk_i);
            #2;
            edges++;
        end
        if (!valid_o) begin
            $display("timeout: no result within %0d cycles of a single request", edges);
            timed_out = 1'b1;
        end else begin
            check_val("latency", LATENCY, edges);
            compare_rsp(e);
            @(posedge clk_i);
            #2;
        end
        report_test("latency after reset", errs);
    endtask

    task automatic test_i2f_exact();
        int errs;
        errs = err_cnt;
        add_op(OP_I2F_S, 32'd0);
        add_op(OP_I2F_S, 32'd1);
        add_op(OP_I2F_S, 32'hffff_ffff);
        add_op(OP_I2F_S, 32'd1000);
        add_op(OP_I2F_U, 32'h8000_0000);
        run_ops(1'b0);
        report_test("int to float exact", errs);
    endtask

    task automatic test_i2f_round();
        int errs;
        errs = err_cnt;
        add_known(OP_I2F_S, 32'd16777217, 32'h4b80_0000, NX);   // tie stays even
        add_known(OP_I2F_S, 32'd16777219, 32'h4b80_0002, NX);   // tie rounds up
        add_known(OP_I2F_S, -32'sd16777217, 32'hcb80_0000, NX);
        run_ops(1'b0);
        report_test("int to float rounding", errs);
    endtask

    task automatic test_f2i_round();
        int errs;
        errs = err_cnt;
        add_known(OP_F2I_S, 32'h4020_0000, 32'd2, NX);          // 2.5
        add_known(OP_F2I_S, 32'h4060_0000, 32'd4, NX);          // 3.5
        add_known(OP_F2I_S, 32'hbfc0_0000, 32'hffff_fffe, NX);  // -1.5
        add_known(OP_F2I_S, 32'h3f80_0000, 32'd1, 5'b0);
        run_ops(1'b0);
        report_test("float to int nearest even", errs);
    endtask

    task automatic test_f2i_special();
        int errs;
        errs = err_cnt;
        add_known(OP_F2I_S, 32'h7fc0_0000, 32'h7fff_ffff, NV);  // quiet nan
        add_known(OP_F2I_S, 32'h7f80_0000, 32'h7fff_ffff, NV);
        add_known(OP_F2I_S, 32'h4f32_d05e, 32'h7fff_ffff, NV);  // about 3e9
        add_known(OP_F2I_S, 32'hff80_0000, 32'h8000_0000, NV);
        add_known(OP_F2I_U, 32'hc040_0000, 32'h0, NV);          // -3.0
        add_known(OP_F2I_U, 32'h4f80_0000, 32'hffff_ffff, NV);  // 2^32
        add_known(OP_F2I_U, 32'hbecc_cccd, 32'h0, NX);          // -0.4
        run_ops(1'b0);
        report_test("float to int special results", errs);
    endtask

    task automatic test_backpressure();
        int errs;
        errs = err_cnt;
        add_op(OP_I2F_S, 32'd16777219);
        add_op(OP_F2I_S, 32'h4060_0000);
        add_op(OP_F2I_U, 32'hc040_0000);
        add_op(OP_I2F_U, 32'hffff_ffff);
        add_op(OP_F2I_S, 32'h7f80_0000);
        add_op(OP_I2F_S, 32'h8000_0001);
        add_op(OP_F2I_S, 32'hbfc0_0000);
        add_op(OP_F2I_U, 32'hbecc_cccd);
        add_op(OP_I2F_S, 32'd123456789);
        add_op(OP_F2I_S, 32'h4eff_ffff);
        add_op(OP_F2I_U, 32'h4f7f_ffff);
        add_op(OP_F2I_S, 32'h0000_0001);   // smallest subnormal
        run_ops(1'b1);
        report_test("back-pressure", errs);
    endtask

    initial begin
        void'($urandom(32'h4ba6));
        reset_i = 1'b1;
        valid_i = 1'b0;
        ready_i = 1'b1;
        req_i   = '0;
        repeat (4) @(posedge clk_i);
        #2;
        reset_i = 1'b0;
        test_latency();
        if (!timed_out) test_i2f_exact();
        if (!timed_out) test_i2f_round();
        if (!timed_out) test_f2i_round();
        if (!timed_out) test_f2i_special();
        if (!timed_out) test_backpressure();
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+design
design/fcvt_pkg.sv
design/fcvt_unpack.sv
design/fcvt_normalize.sv
design/fcvt_align.sv
design/fcvt_round.sv
design/fcvt_finish.sv
design/fcvt_top.sv
tests/fcvt_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the converter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module fcvt_tb -f src.f -o fcvt_sim

out=$(./obj_dir/fcvt_sim)
echo "$out"

# exits nonzero unless the pass line is present
echo "$out" | grep -qx "=== PASS ==="
